// File: aer_readout.f
+incdir+src
src/aer_pkg.sv
src/aer_lane_if.sv
src/event_router.sv
src/event_encoder.sv
src/event_merger.sv
src/aer_readout.sv
verification/aer_readout_asserts.sv
verification/aer_readout_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the AER readout testbench with Verilator.
set -e
set -o pipefail 2>/dev/null || true

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module aer_readout_tb \
  -f aer_readout.f \
  -o aer_readout_sim

./obj_dir/aer_readout_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi

echo "simulation finished without failure"

// File: verification/aer_readout_tb.sv
`default_nettype none

`include "aer_config.svh"

module aer_readout_tb;
  import aer_pkg::*;

  localparam int CLK_PERIOD    = 8;
  localparam int RANDOM_EVENTS = 200;
  // random events take at most 5 cycles each, directed tests well under 600
  localparam int WATCHDOG_CYCLES = RANDOM_EVENTS * 6 + 600;
  // sampling-edge distance that closes a lane session
  localparam int SESSION_GAP = `AER_SESSION_CYCLES + 1;

  logic       clk_i;
  logic       reset_i;
  logic       event_valid_i;
  logic       event_polarity_i;
  row_addr_t  event_row_i;
  col_addr_t  event_col_i;
  timestamp_t timestamp_i;
  logic       word_valid_o;
  aer_word_t  word_o;
  lane_id_t   word_lane_o;

  // scoreboard, one queue of expected words per lane
  aer_word_t  exp_q [`AER_NUM_LANES][$];
  // reference model of each lane
  logic       lane_seen   [`AER_NUM_LANES];
  time_high_t lane_th     [`AER_NUM_LANES];
  int         lane_launch [`AER_NUM_LANES];

  int cyc = 0;
  int errors = 0;
  int seed = 88936;

  aer_readout UUT (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .event_valid_i    (event_valid_i),
    .event_polarity_i (event_polarity_i),
    .event_row_i      (event_row_i),
    .event_col_i      (event_col_i),
    .timestamp_i      (timestamp_i),
    .word_valid_o     (word_valid_o),
    .word_o           (word_o),
    .word_lane_o      (word_lane_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i)
    cyc <= cyc + 1;

  // ------------------------------
  // reference model
  // ------------------------------

  // expected words for one event, from the word format rules
  task automatic predict_event(input logic pol, input row_addr_t row, input col_addr_t col,
                               input timestamp_t ts, input int launch);
    lane_id_t   lane;
    time_high_t th;
    logic       need_th;
    lane = lane_id_t'(row >> (`AER_ROW_BITS - $bits(lane_id_t)));
    th   = ts[`AER_TS_BITS-1:`AER_TS_LOW_BITS];
    // new session or new window needs a time-high word
    need_th = !lane_seen[lane] || (launch - lane_launch[lane] >= SESSION_GAP)
              || (th != lane_th[lane]);
    if (need_th)
      exp_q[lane].push_back({4'b1000, th});
    exp_q[lane].push_back({pol ? 4'b0001 : 4'b0000, ts[`AER_TS_LOW_BITS-1:0], row, col});
    lane_seen[lane]   = 1'b1;
    lane_th[lane]     = th;
    lane_launch[lane] = launch;
  endtask

  function automatic int pending_words();
    int total;
    total = 0;
    for (int l = 0; l < `AER_NUM_LANES; l++)
      total += exp_q[l].size();
    return total;
  endfunction

  // ------------------------------
  // stimulus helpers
  // ------------------------------

  // one-cycle strobe, launch is the cycle count during the strobe
  task automatic drive_event(input logic pol, input row_addr_t row, input col_addr_t col,
                             input timestamp_t ts, output int launch);
    @(posedge clk_i);
    event_valid_i    <= 1'b1;
    event_polarity_i <= pol;
    event_row_i      <= row;
    event_col_i      <= col;
    timestamp_i      <= ts;
    // cycle count sampled mid-strobe
    @(negedge clk_i);
    launch = cyc;
    predict_event(pol, row, col, ts, launch);
    @(posedge clk_i);
    event_valid_i <= 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  // wait for the scoreboard to empty, bounded
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (pending_words() != 0 && waited < 100)
    begin
      @(negedge clk_i);
      waited++;
    end
    assert (pending_words() == 0)
    else
    begin
      errors++;
      $display("expected words still missing after 100 cycles: %0d", pending_words());
    end
    idle_cycles(4);
  endtask

  // ------------------------------
  // output monitor
  // ------------------------------

  task automatic check_output();
    aer_word_t exp_word;
    assert (exp_q[word_lane_o].size() != 0)
    else
    begin
      errors++;
      $display("unexpected word %h on lane %0d, none was expected", word_o, word_lane_o);
    end
    if (exp_q[word_lane_o].size() != 0)
    begin
      exp_word = exp_q[word_lane_o].pop_front();
      assert (word_o == exp_word)
      else
      begin
        errors++;
        $display("** Error: word_o = %h, expected %h (word_lane_o = %h)",
                 word_o, exp_word, word_lane_o);
      end
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk_i)
  begin
    if (!reset_i && word_valid_o)
      check_output();
  end

  // ------------------------------
  // directed tests
  // ------------------------------

  task automatic test_reset();
    repeat (3)
    begin
      @(negedge clk_i);
      assert (word_valid_o === 1'b0)
      else
      begin
        errors++;
        $display("** Error: word_valid_o = %h during reset, expected 0", word_valid_o);
      end
      @(posedge clk_i);
    end
    reset_i <= 1'b0;
    repeat (10)
    begin
      @(negedge clk_i);
      assert (word_valid_o === 1'b0)
      else
      begin
        errors++;
        $display("** Error: word_valid_o = %h with no events, expected 0", word_valid_o);
      end
    end
  endtask

  // idle lane 2, fixed latency of 3 and 4 cycles
  task automatic test_single_event();
    int launch;
    int first;
    int second;
    first  = -1;
    second = -1;
    drive_event(1'b1, {2'b10, 9'h0A5}, 11'h3C7, 34'h2_3456_789A, launch);
    for (int w = 0; w < 12; w++)
    begin
      @(negedge clk_i);
      if (word_valid_o)
      begin
        assert (word_lane_o == 2'd2)
        else
        begin
          errors++;
          $display("** Error: word_lane_o = %h, expected %h", word_lane_o, 2'd2);
        end
        if (first < 0)
          first = cyc - launch;
        else if (second < 0)
          second = cyc - launch;
      end
    end
    assert (first == 3 && second == 4)
    else
    begin
      errors++;
      $display("words came %0d and %0d cycles after the strobe, expected 3 and 4",
               first, second);
    end
    wait_drain();
  endtask

  // one window on lane 1, mixed polarities
  task automatic test_same_window();
    int launch;
    timestamp_t base;
    base = 34'h0_1234_5600;
    drive_event(1'b1, {2'b01, 9'h011}, 11'h001, base + 2, launch);
    drive_event(1'b0, {2'b01, 9'h012}, 11'h002, base + 5, launch);
    drive_event(1'b0, {2'b01, 9'h013}, 11'h003, base + 9, launch);
    idle_cycles(1);
    drive_event(1'b1, {2'b01, 9'h1FF}, 11'h7FF, base + 20, launch);
    drive_event(1'b1, {2'b01, 9'h000}, 11'h400, base + 33, launch);
    wait_drain();
  endtask

  // lane 3 steps across a multiple of 64
  task automatic test_time_high_change();
    int launch;
    timestamp_t base;
    base = 34'h1_ABCD_EF3C;
    drive_event(1'b0, {2'b11, 9'h101}, 11'h055, base, launch);
    drive_event(1'b1, {2'b11, 9'h102}, 11'h056, base + 2, launch);
    drive_event(1'b0, {2'b11, 9'h103}, 11'h057, base + 3, launch);
    drive_event(1'b1, {2'b11, 9'h104}, 11'h058, base + 4, launch);
    drive_event(1'b1, {2'b11, 9'h105}, 11'h059, base + 6, launch);
    wait_drain();
  endtask

  // quiet gap closes the session on lane 0
  task automatic test_session_end();
    int launch;
    drive_event(1'b1, {2'b00, 9'h0F0}, 11'h123, 34'h0_0000_4441, launch);
    wait_drain();
    idle_cycles(SESSION_GAP + 8);
    drive_event(1'b0, {2'b00, 9'h0F1}, 11'h124, 34'h0_0000_4442, launch);
    wait_drain();
  endtask

  // random lanes and addresses, rising timestamps
  task automatic test_interleaved();
    int launch;
    int r;
    logic pol;
    row_addr_t row;
    col_addr_t col;
    timestamp_t ts;
    ts = 34'h0_0100_0000;
    for (int n = 0; n < RANDOM_EVENTS; n++)
    begin
      r   = $random(seed);
      pol = r[0];
      row = row_addr_t'($random(seed));
      col = col_addr_t'($random(seed));
      ts  = ts + 1 + timestamp_t'($random(seed) & 63);
      drive_event(pol, row, col, ts, launch);
      idle_cycles($random(seed) & 3);
    end
    wait_drain();
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial
  begin
    reset_i          = 1'b1;
    event_valid_i    = 1'b0;
    event_polarity_i = 1'b0;
    event_row_i      = '0;
    event_col_i      = '0;
    timestamp_i      = '0;
    for (int l = 0; l < `AER_NUM_LANES; l++)
    begin
      lane_seen[l]   = 1'b0;
      lane_th[l]     = '0;
      lane_launch[l] = 0;
    end

    test_reset();
    test_single_event();
    test_same_window();
    test_time_high_change();
    test_session_end();
    test_interleaved();

    $display("checks done, errors: %0d", errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/aer_readout_asserts.sv
`default_nettype none

`include "aer_config.svh"

module aer_readout_asserts (
  input logic                      clk_i,
  input logic                      reset_i,
  input logic                      word_valid_i,
  input aer_pkg::lane_id_t         word_lane_i,
  input logic [`AER_NUM_LANES-1:0] fifo_push_i,
  input logic [`AER_NUM_LANES-1:0] fifo_full_i,
  input logic [`AER_NUM_LANES-1:0] enc_valid_i,
  input logic [`AER_NUM_LANES-1:0] enc_time_high_i,
  input logic [`AER_NUM_LANES-1:0] enc_event_i
);
  import aer_pkg::*;

  // words written into each lane and not yet shown on the port
  int in_flight [`AER_NUM_LANES];

  // ------------------------------
  // merger
  // ------------------------------

  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      for (int l = 0; l < `AER_NUM_LANES; l++)
        in_flight[l] <= 0;
    end
    else
    begin
      for (int l = 0; l < `AER_NUM_LANES; l++)
        in_flight[l] <= in_flight[l] + int'(fifo_push_i[l])
                        - int'(word_valid_i && (word_lane_i == lane_id_t'(l)));
    end
  end

  // lane number on the port names a real tile that still holds a word
  a_lane_range: assert property (@(posedge clk_i) disable iff (reset_i)
    word_valid_i |-> ((int'(word_lane_i) < `AER_NUM_LANES) && (in_flight[word_lane_i] > 0)))
    else $error("output lane number out of range or lane has no word");

  for (genvar l = 0; l < `AER_NUM_LANES; l++)
  begin : g_lane
    // input spacing keeps every lane FIFO below full
    a_no_overfill: assert property (@(posedge clk_i) disable iff (reset_i)
      !(fifo_push_i[l] && fifo_full_i[l]))
      else $error("write into a full lane FIFO");

    // time-high word only right after an event strobe on its lane
    a_th_after_event: assert property (@(posedge clk_i) disable iff (reset_i)
      (enc_valid_i[l] && enc_time_high_i[l]) |-> $past(enc_event_i[l]))
      else $error("encoder sent a time-high word without an event");
  end

endmodule

// hooks into the merger and the four encoders of the top level
bind aer_readout aer_readout_asserts u_asserts (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .word_valid_i    (word_valid_o),
  .word_lane_i     (word_lane_o),
  .fifo_push_i     (u_merger.push),
  .fifo_full_i     ({u_merger.count_q[3] == `AER_FIFO_DEPTH,
                     u_merger.count_q[2] == `AER_FIFO_DEPTH,
                     u_merger.count_q[1] == `AER_FIFO_DEPTH,
                     u_merger.count_q[0] == `AER_FIFO_DEPTH}),
  .enc_valid_i     ({g_enc[3].u_encoder.word_valid_o,
                     g_enc[2].u_encoder.word_valid_o,
                     g_enc[1].u_encoder.word_valid_o,
                     g_enc[0].u_encoder.word_valid_o}),
  .enc_time_high_i ({g_enc[3].u_encoder.word_o[31:28] == aer_pkg::TYPE_TIME_HIGH,
                     g_enc[2].u_encoder.word_o[31:28] == aer_pkg::TYPE_TIME_HIGH,
                     g_enc[1].u_encoder.word_o[31:28] == aer_pkg::TYPE_TIME_HIGH,
                     g_enc[0].u_encoder.word_o[31:28] == aer_pkg::TYPE_TIME_HIGH}),
  .enc_event_i     ({lane_if[3].enable,
                     lane_if[2].enable,
                     lane_if[1].enable,
                     lane_if[0].enable})
);

`default_nettype wire

// File: src/aer_readout.sv
`default_nettype none

`include "aer_config.svh"

module aer_readout (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                event_valid_i,
  input  logic                event_polarity_i,
  input  aer_pkg::row_addr_t  event_row_i,
  input  aer_pkg::col_addr_t  event_col_i,
  input  aer_pkg::timestamp_t timestamp_i,
  output logic                word_valid_o,
  output aer_pkg::aer_word_t  word_o,
  output aer_pkg::lane_id_t   word_lane_o
);
  import aer_pkg::*;

  // encoder outputs, one element per lane
  aer_word_t enc_word       [`AER_NUM_LANES];
  logic      enc_word_valid [`AER_NUM_LANES];

  // router to encoder links
  aer_lane_if lane_if [`AER_NUM_LANES] ();

  // ------------------------------
  // tile routing
  // ------------------------------

  event_router u_router (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .event_valid_i    (event_valid_i),
    .event_polarity_i (event_polarity_i),
    .event_row_i      (event_row_i),
    .event_col_i      (event_col_i),
    .timestamp_i      (timestamp_i),
    .lane_o           (lane_if)
  );

  // one encoder per tile
  for (genvar g = 0; g < `AER_NUM_LANES; g++)
  begin : g_enc
    event_encoder u_encoder (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .lane_i       (lane_if[g]),
      .word_o       (enc_word[g]),
      .word_valid_o (enc_word_valid[g])
    );
  end

  // ------------------------------
  // output merge
  // ------------------------------

  event_merger u_merger (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .word_i       (enc_word),
    .word_valid_i (enc_word_valid),
    .word_o       (word_o),
    .word_valid_o (word_valid_o),
    .word_lane_o  (word_lane_o)
  );

endmodule

`default_nettype wire

// File: src/event_merger.sv
`default_nettype none

`include "aer_config.svh"

module event_merger (
  input  logic               clk_i,
  input  logic               reset_i,
  input  aer_pkg::aer_word_t word_i       [`AER_NUM_LANES],
  input  logic               word_valid_i [`AER_NUM_LANES],
  output aer_pkg::aer_word_t word_o,
  output logic               word_valid_o,
  output aer_pkg::lane_id_t  word_lane_o
);
  import aer_pkg::*;

  localparam int DEPTH = `AER_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  aer_word_t                 fifo_mem_q [`AER_NUM_LANES][DEPTH];
  ptr_t                      wr_ptr_q   [`AER_NUM_LANES];
  ptr_t                      rd_ptr_q   [`AER_NUM_LANES];
  cnt_t                      count_q    [`AER_NUM_LANES];
  aer_word_t                 head_word  [`AER_NUM_LANES];
  logic [`AER_NUM_LANES-1:0] push;
  logic [`AER_NUM_LANES-1:0] pop;
  logic [`AER_NUM_LANES-1:0] has_data;
  logic                      grant_valid;
  lane_id_t                  grant_lane;
  lane_id_t                  last_lane_q;

  // circular pointer step
  function automatic ptr_t ptr_next(input ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? '0 : ptr_t'(p + 1'b1);
  endfunction

  // ------------------------------
  // per-lane FIFOs
  // ------------------------------

  for (genvar l = 0; l < `AER_NUM_LANES; l++)
  begin : g_fifo
    assign push[l] = word_valid_i[l];
    assign pop[l]  = grant_valid && (grant_lane == lane_id_t'(l));

    // an incoming word counts as data in its own cycle
    assign has_data[l]  = (count_q[l] != '0) || push[l];
    // empty FIFO falls through to the input
    assign head_word[l] = (count_q[l] == '0) ? word_i[l] : fifo_mem_q[l][rd_ptr_q[l]];

    always_ff @(posedge clk_i)
    begin
      if (push[l])
        fifo_mem_q[l][wr_ptr_q[l]] <= word_i[l];
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
      if (reset_i)
      begin
        wr_ptr_q[l] <= '0;
        rd_ptr_q[l] <= '0;
        count_q[l]  <= '0;
      end
      else
      begin
        if (push[l])
          wr_ptr_q[l] <= ptr_next(wr_ptr_q[l]);
        if (pop[l])
          rd_ptr_q[l] <= ptr_next(rd_ptr_q[l]);
        // push and pop together leave the fill level alone
        case ({push[l], pop[l]})
          2'b10:   count_q[l] <= count_q[l] + 1'b1;
          2'b01:   count_q[l] <= count_q[l] - 1'b1;
          default: count_q[l] <= count_q[l];
        endcase
      end
    end
  end

  // ------------------------------
  // round-robin select
  // ------------------------------

  // search starts one past the lane served last
  always_comb
  begin
    lane_id_t cand;
    grant_valid = 1'b0;
    grant_lane  = last_lane_q;
    for (int k = 1; k <= `AER_NUM_LANES; k++)
    begin
      cand = lane_id_t'((int'(last_lane_q) + k) % `AER_NUM_LANES);
      if (!grant_valid && has_data[cand])
      begin
        grant_valid = 1'b1;
        grant_lane  = cand;
      end
    end
  end

  // output register, one word per cycle
  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      word_valid_o <= 1'b0;
      // lane 0 gets first turn
      last_lane_q  <= lane_id_t'(`AER_NUM_LANES - 1);
    end
    else
    begin
      word_valid_o <= grant_valid;
      if (grant_valid)
        last_lane_q <= grant_lane;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (grant_valid)
      word_o <= head_word[grant_lane];
  end

  // lane of the word on the port is the lane served last
  assign word_lane_o = last_lane_q;

endmodule

`default_nettype wire

// File: src/event_encoder.sv
`default_nettype none

`include "aer_config.svh"

module event_encoder (
  input  logic               clk_i,
  input  logic               reset_i,
  aer_lane_if.encoder_mp     lane_i,
  output aer_pkg::aer_word_t word_o,
  output logic               word_valid_o
);
  import aer_pkg::*;

  enc_state_t state_q;
  enc_state_t state_d;
  time_high_t last_th_q;
  time_high_t ev_th;
  time_low_t  ev_tl;
  aer_word_t  ev_word;
  aer_word_t  th_word;
  aer_word_t  hold_word_q;
  aer_word_t  word_d;
  logic       word_valid_d;
  logic       hold_load;
  logic       th_change;

  // ------------------------------
  // word formatting
  // ------------------------------

  // split the timestamp
  assign ev_th = lane_i.timestamp[`AER_TS_BITS-1:`AER_TS_LOW_BITS];
  assign ev_tl = lane_i.timestamp[`AER_TS_LOW_BITS-1:0];

  // polarity selects the ON or OFF nibble
  assign ev_word = {lane_i.polarity ? TYPE_CD_ON : TYPE_CD_OFF, ev_tl, lane_i.row, lane_i.col};
  assign th_word = {TYPE_TIME_HIGH, ev_th};

  // upper time moved since the last time-high word
  assign th_change = (ev_th != last_th_q);

  // ------------------------------
  // next state and output
  // ------------------------------

  always_comb
  begin
    state_d      = state_q;
    word_d       = ev_word;
    word_valid_d = 1'b0;
    hold_load    = 1'b0;

    case (state_q)
      IDLE:
      begin
        // first event of a session always needs a time-high word
        if (lane_i.enable)
        begin
          word_d       = th_word;
          word_valid_d = 1'b1;
          hold_load    = 1'b1;
          state_d      = TIME_HIGH;
        end
      end

      TIME_HIGH:
      begin
        // held event follows its time-high word
        word_d       = hold_word_q;
        word_valid_d = 1'b1;
        state_d      = STREAM;
      end

      STREAM:
      begin
        if (lane_i.enable)
        begin
          if (th_change)
          begin
            word_d       = th_word;
            word_valid_d = 1'b1;
            hold_load    = 1'b1;
            state_d      = TIME_HIGH;
          end
          else
          begin
            // same window, event word straight out
            word_d       = ev_word;
            word_valid_d = 1'b1;
          end
        end
        else if (!lane_i.active_req)
        begin
          // session over, next event resends the upper time
          state_d = IDLE;
        end
      end

      default:
        state_d = IDLE;
    endcase
  end

  // ------------------------------
  // registers
  // ------------------------------

  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      state_q      <= IDLE;
      word_valid_o <= 1'b0;
      last_th_q    <= '0;
    end
    else
    begin
      state_q      <= state_d;
      word_valid_o <= word_valid_d;
      // remember what the decoder now knows
      if (hold_load)
        last_th_q <= ev_th;
    end
  end

  // one-event hold and output word
  always_ff @(posedge clk_i)
  begin
    if (hold_load)
      hold_word_q <= ev_word;
    if (word_valid_d)
      word_o <= word_d;
  end

endmodule

`default_nettype wire

// File: src/event_router.sv
`default_nettype none

`include "aer_config.svh"

module event_router (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                event_valid_i,
  input  logic                event_polarity_i,
  input  aer_pkg::row_addr_t  event_row_i,
  input  aer_pkg::col_addr_t  event_col_i,
  input  aer_pkg::timestamp_t timestamp_i,
  aer_lane_if.router_mp       lane_o [`AER_NUM_LANES]
);
  import aer_pkg::*;

  // tile select bits at the top of the row address
  localparam int LANE_BITS = $bits(lane_id_t);
  // session counter wide enough for the reload value
  localparam int SESS_W = $clog2(`AER_SESSION_CYCLES + 1);
  localparam logic [SESS_W-1:0] SESS_RELOAD = SESS_W'(`AER_SESSION_CYCLES);

  lane_id_t                  lane_sel;
  logic [`AER_NUM_LANES-1:0] enable_q;
  logic                      polarity_q;
  row_addr_t                 row_q;
  col_addr_t                 col_q;
  timestamp_t                ts_q;
  logic [SESS_W-1:0]         sess_cnt_q [`AER_NUM_LANES];

  // ------------------------------
  // lane decode
  // ------------------------------

  // upper row bits pick the tile
  assign lane_sel = lane_id_t'(event_row_i[`AER_ROW_BITS-1 -: LANE_BITS]);

  // one-hot strobe, only the addressed lane fires
  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      enable_q <= '0;
    end
    else
    begin
      enable_q <= '0;
      if (event_valid_i)
        enable_q[lane_sel] <= 1'b1;
    end
  end

  // event payload, shared by all lanes
  always_ff @(posedge clk_i)
  begin
    if (event_valid_i)
    begin
      polarity_q <= event_polarity_i;
      row_q      <= event_row_i;
      col_q      <= event_col_i;
      ts_q       <= timestamp_i;
    end
  end

  // ------------------------------
  // per-lane sessions
  // ------------------------------

  for (genvar l = 0; l < `AER_NUM_LANES; l++)
  begin : g_lane
    // reload on an event for this tile, count down while quiet
    always_ff @(posedge clk_i or posedge reset_i)
    begin
      if (reset_i)
        sess_cnt_q[l] <= '0;
      else if (event_valid_i && (lane_sel == lane_id_t'(l)))
        sess_cnt_q[l] <= SESS_RELOAD;
      else if (sess_cnt_q[l] != '0)
        sess_cnt_q[l] <= sess_cnt_q[l] - 1'b1;
    end

    // session open while the counter runs
    assign lane_o[l].active_req = (sess_cnt_q[l] != '0);
    assign lane_o[l].enable     = enable_q[l];
    assign lane_o[l].polarity   = polarity_q;
    assign lane_o[l].row        = row_q;
    assign lane_o[l].col        = col_q;
    assign lane_o[l].timestamp  = ts_q;
  end

endmodule

`default_nettype wire

// File: src/aer_lane_if.sv
`default_nettype none

`include "aer_config.svh"

interface aer_lane_if;
  import aer_pkg::*;

  // session level for this tile
  logic       active_req;
  // one-cycle event strobe
  logic       enable;
  // payload, only valid with enable
  logic       polarity;
  row_addr_t  row;
  col_addr_t  col;
  timestamp_t timestamp;

  // router side
  modport router_mp (
    output active_req,
    output enable,
    output polarity,
    output row,
    output col,
    output timestamp
  );

  // encoder side
  modport encoder_mp (
    input active_req,
    input enable,
    input polarity,
    input row,
    input col,
    input timestamp
  );

endinterface

`default_nettype wire

// File: src/aer_pkg.sv
`default_nettype none

`include "aer_config.svh"

package aer_pkg;

  // ------------------------------
  // address and time types
  // ------------------------------

  // pixel addresses
  typedef logic [`AER_ROW_BITS-1:0] row_addr_t;
  typedef logic [`AER_COL_BITS-1:0] col_addr_t;

  // full timestamp from the external time base
  typedef logic [`AER_TS_BITS-1:0] timestamp_t;

  // upper timestamp field sent in time-high words
  typedef logic [`AER_TS_BITS-`AER_TS_LOW_BITS-1:0] time_high_t;

  // lower timestamp field sent in event words
  typedef logic [`AER_TS_LOW_BITS-1:0] time_low_t;

  // one output word
  typedef logic [`AER_WORD_BITS-1:0] aer_word_t;

  // lane number, one lane per tile
  typedef logic [$clog2(`AER_NUM_LANES)-1:0] lane_id_t;

  // ------------------------------
  // word type nibbles
  // ------------------------------

  localparam logic [3:0] TYPE_TIME_HIGH = 4'b1000;
  localparam logic [3:0] TYPE_CD_ON     = 4'b0001;
  localparam logic [3:0] TYPE_CD_OFF    = 4'b0000;

  // encoder states
  // TIME_HIGH holds one event while its time-high word goes out
  typedef enum logic [1:0] {
    IDLE,
    TIME_HIGH,
    STREAM
  } enc_state_t;

endpackage

`default_nettype wire

// File: src/aer_config.svh
`ifndef AER_CONFIG_SVH
`define AER_CONFIG_SVH

// ------------------------------
// sensor geometry
// ------------------------------

// one lane per sensor tile
`define AER_NUM_LANES 4

// pixel address widths
`define AER_ROW_BITS 11
`define AER_COL_BITS 11

// ------------------------------
// time base and word format
// ------------------------------

// external timestamp width
`define AER_TS_BITS 34

// low field carried in every event word
`define AER_TS_LOW_BITS 6

// width of one AER word on the output port
`define AER_WORD_BITS 32

// ------------------------------
// readout behaviour
// ------------------------------

// quiet cycles before a tile session closes
`define AER_SESSION_CYCLES 16

// words buffered per lane in the merger
`define AER_FIFO_DEPTH 4

`endif
